/* Bender.yml */
package:
  name: refmux_test

sources:
  - include_dirs:
      - logic
    files:
      - logic/refmux_pkg.sv
      - logic/refmux_param_regs.sv
      - logic/refmux_modulator.sv
      - logic/refmux_monitor_collect.sv
      - logic/refmux_test_top.sv

  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/refmux_test_tb.sv

/* all.f */
+incdir+logic
logic/refmux_pkg.sv
logic/refmux_param_regs.sv
logic/refmux_modulator.sv
logic/refmux_monitor_collect.sv
logic/refmux_test_top.sv
testbench/refmux_test_tb.sv

/* logic/refmux_config.svh */
// build-time sizes for the refmux bench subsystem
// include wherever the channel count or a width is needed
`ifndef REFMUX_CONFIG_SVH
`define REFMUX_CONFIG_SVH

////////////////////
// channel count

`define REFMUX_NUM_CHAN 4 // identical modulator channels

////////////////////
// widths

`define REFMUX_COUNT_WIDTH 24 // reset and fix phase lengths
`define REFMUX_PERIOD_WIDTH 16 // completed pos/neg periods, saturating

// register map, run mask lives at the top address
`define REFMUX_RUN_ADDR 4'hf

`endif

/* logic/refmux_modulator.sv */
// one refmux channel, integrator reset then alternating pos/neg fix phases
// counts come from cfg_i at each phase start, status goes to the collector
`timescale 1ns/1ps
`include "refmux_config.svh"

module refmux_modulator (
  input  logic                     clk,
  input  logic                     reset_i,
  input  refmux_pkg::chan_cfg_t    cfg_i,
  input  logic                     cmp_i,
  output refmux_pkg::chan_status_t status_o
);

  import refmux_pkg::*;

  ////////////////////
  // state

  mod_state_e   state_q;   // sequencer
  clk_count_t   count_q;   // phase down counter
  refmux_code_e code_q;    // registered switch code
  logic         cmp_pos_q; // comparator at end of last pos phase
  logic         cmp_neg_q; // comparator at end of last neg phase

  logic count_zero; // current phase ends this cycle or next start

  assign count_zero = (count_q == '0);

  ////////////////////
  // sequencer

  // the start state is the last cycle of the old code, so the
  // counter gets count-1 and the new code shows count+1 cycles
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      state_q   <= IDLE;
      count_q   <= '0;
      code_q    <= REFMUX_NONE;
      cmp_pos_q <= 1'b0;
      cmp_neg_q <= 1'b0;
    end
    else if (!cfg_i.run)
    begin
      // stop at once, both refs off
      state_q <= IDLE;
      code_q  <= REFMUX_NONE;
    end
    else
    begin
      case (state_q)

        IDLE:
          state_q <= RESET_START; // run just went high

        RESET_START:
        begin
          state_q   <= RESET;
          count_q   <= cfg_i.reset_count - 1'b1;
          code_q    <= REFMUX_RESET; // short the integrator
          cmp_pos_q <= 1'b0;         // fresh run, no samples yet
          cmp_neg_q <= 1'b0;
        end

        RESET:
        begin
          count_q <= count_q - 1'b1;
          if (count_zero)
            state_q <= FIX_POS_START;
        end

        FIX_POS_START:
        begin
          state_q <= FIX_POS;
          count_q <= cfg_i.fix_count - 1'b1;
          code_q  <= REFMUX_POS;
          // only a neg phase ending here gives a neg sample
          if (code_q == REFMUX_NEG)
            cmp_neg_q <= cmp_i;
        end

        FIX_POS:
        begin
          count_q <= count_q - 1'b1;
          if (count_zero)
            state_q <= FIX_NEG_START;
        end

        FIX_NEG_START:
        begin
          state_q   <= FIX_NEG;
          count_q   <= cfg_i.fix_count - 1'b1;
          code_q    <= REFMUX_NEG;
          cmp_pos_q <= cmp_i; // last cycle of the pos phase
        end

        FIX_NEG:
        begin
          count_q <= count_q - 1'b1;
          if (count_zero)
            state_q <= FIX_POS_START; // no 3-phase variant, back to pos
        end

        default:
        begin
          state_q <= IDLE;
          code_q  <= REFMUX_NONE;
        end

      endcase
    end
  end

  ////////////////////
  // status out

  assign status_o.refmux = code_q;

  // phase bits track the code, so idle and reset read 00
  assign status_o.monitor = {
    1'b0,                   // spare
    cfg_i.run,
    cmp_neg_q,
    cmp_pos_q,
    code_q == REFMUX_NEG,
    code_q == REFMUX_POS
  };

  // neg phase ends in the pos start state
  assign status_o.period_done = (state_q == FIX_POS_START) && (code_q == REFMUX_NEG);

endmodule

/* logic/refmux_monitor_collect.sv */
// gathers channel status, counts finished periods per channel
// and registers the selected channel onto the monitor outputs
`timescale 1ns/1ps
`include "refmux_config.svh"

module refmux_monitor_collect (
  input  logic                                            clk,
  input  logic                                            reset_i,
  input  refmux_pkg::chan_status_t [`REFMUX_NUM_CHAN-1:0] status_i,
  input  refmux_pkg::chan_idx_t                           mon_sel_i,
  output logic [5:0]                                      monitor_o,
  output refmux_pkg::period_count_t                       period_count_o
);

  import refmux_pkg::*;

  localparam int MON_RUN_BIT = 4; // run flag inside the status monitor

  ////////////////////
  // per channel

  logic [`REFMUX_NUM_CHAN-1:0] run_q;      // last run level, edge detect
  period_count_t               period_q [`REFMUX_NUM_CHAN];
  logic [`REFMUX_NUM_CHAN-1:0] run_rise;   // channel restarted

  always_comb
  begin
    for (int k = 0; k < `REFMUX_NUM_CHAN; k++)
      run_rise[k] = status_i[k].monitor[MON_RUN_BIT] && !run_q[k];
  end

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      run_q <= '0;
      for (int k = 0; k < `REFMUX_NUM_CHAN; k++)
        period_q[k] <= '0;
    end
    else
    begin
      for (int k = 0; k < `REFMUX_NUM_CHAN; k++)
      begin
        run_q[k] <= status_i[k].monitor[MON_RUN_BIT];
        if (run_rise[k])
          period_q[k] <= '0; // new run, count from zero
        else if (status_i[k].period_done && (period_q[k] != '1))
          period_q[k] <= period_q[k] + 1'b1; // saturates at all ones
      end
    end
  end

  ////////////////////
  // selected channel out

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      monitor_o      <= '0;
      period_count_o <= '0;
    end
    else if (mon_sel_i < `REFMUX_NUM_CHAN)
    begin
      monitor_o      <= status_i[mon_sel_i].monitor;
      period_count_o <= period_q[mon_sel_i];
    end
    else
    begin
      monitor_o      <= '0; // no such channel
      period_count_o <= '0;
    end
  end

endmodule

/* logic/refmux_param_regs.sv */
// count registers and run mask for all modulator channels
// loaded from a plain write strobe, one config struct out per channel
`timescale 1ns/1ps
`include "refmux_config.svh"

module refmux_param_regs (
  input  logic                                           clk,
  input  logic                                           reset_i,
  input  logic                                           cfg_we_i,
  input  refmux_pkg::cfg_addr_t                          cfg_addr_i,
  input  logic [`REFMUX_COUNT_WIDTH-1:0]                 cfg_wdata_i,
  output refmux_pkg::chan_cfg_t [`REFMUX_NUM_CHAN-1:0]   chan_cfg_o
);

  import refmux_pkg::*;

  ////////////////////
  // storage

  clk_count_t                 reset_count_q [`REFMUX_NUM_CHAN]; // per channel
  clk_count_t                 fix_count_q   [`REFMUX_NUM_CHAN];
  logic [`REFMUX_NUM_CHAN-1:0] run_q;                            // one bit per channel

  logic run_sel; // write hits the run mask

  assign run_sel = (cfg_addr_i == cfg_addr_t'(`REFMUX_RUN_ADDR));

  ////////////////////
  // write decode

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      // counts default to 1, the shortest legal phase
      for (int k = 0; k < `REFMUX_NUM_CHAN; k++)
      begin
        reset_count_q[k] <= clk_count_t'(1);
        fix_count_q[k]   <= clk_count_t'(1);
      end
      run_q <= '0; // all channels stopped
    end
    else if (cfg_we_i)
    begin
      if (run_sel)
      begin
        run_q <= cfg_wdata_i[`REFMUX_NUM_CHAN-1:0]; // low bits only
      end
      else
      begin
        // even address reset count, odd address fix count
        for (int k = 0; k < `REFMUX_NUM_CHAN; k++)
        begin
          if (cfg_addr_i == cfg_addr_t'(2 * k))
            reset_count_q[k] <= cfg_wdata_i;
          if (cfg_addr_i == cfg_addr_t'(2 * k + 1))
            fix_count_q[k] <= cfg_wdata_i;
        end
        // anything past the last channel falls through, ignored
      end
    end
  end

  ////////////////////
  // fan out

  always_comb
  begin
    for (int k = 0; k < `REFMUX_NUM_CHAN; k++)
    begin
      chan_cfg_o[k].reset_count = reset_count_q[k];
      chan_cfg_o[k].fix_count   = fix_count_q[k];
      chan_cfg_o[k].run         = run_q[k];
    end
  end

endmodule

/* logic/refmux_pkg.sv */
// shared types for the refmux modulator bench subsystem
// import inside module bodies, scoped names in port lists
`include "refmux_config.svh"

package refmux_pkg;

  ////////////////////
  // plain vectors

  typedef logic [`REFMUX_COUNT_WIDTH-1:0] clk_count_t; // phase length in clocks
  typedef logic [$clog2(`REFMUX_NUM_CHAN)-1:0] chan_idx_t; // channel select
  typedef logic [`REFMUX_PERIOD_WIDTH-1:0] period_count_t; // done periods
  typedef logic [3:0] cfg_addr_t; // 2k reset, 2k+1 fix, 15 run mask

  ////////////////////
  // encodings

  // switch codes, one bit per analog switch leg
  typedef enum logic [2:0] {
    REFMUX_NONE  = 3'b000, // both refs off, keeps the switching balanced
    REFMUX_POS   = 3'b001,
    REFMUX_NEG   = 3'b010,
    REFMUX_RESET = 3'b100  // integrator shorted
  } refmux_code_e;

  typedef enum logic [2:0] {
    IDLE,
    RESET_START,
    RESET,
    FIX_POS_START,
    FIX_POS,
    FIX_NEG_START,
    FIX_NEG
  } mod_state_e;

  ////////////////////
  // per channel bundles

  typedef struct packed {
    clk_count_t reset_count; // integrator reset length
    clk_count_t fix_count;   // each pos or neg phase
    logic       run;
  } chan_cfg_t;

  typedef struct packed {
    refmux_code_e refmux;      // current switch code
    logic [5:0]   monitor;     // {0, run, cmp neg, cmp pos, phase}
    logic         period_done; // last cycle of a neg phase
  } chan_status_t;

endpackage

/* logic/refmux_test_top.sv */
// bench top for the refmux channels, register file, modulators, collector
// drive the write port, then watch refmux_o and the selected monitor
`timescale 1ns/1ps
`include "refmux_config.svh"

module refmux_test_top (
  input  logic                              clk,
  input  logic                              reset_i,
  input  logic                              cfg_we_i,
  input  refmux_pkg::cfg_addr_t             cfg_addr_i,
  input  logic [`REFMUX_COUNT_WIDTH-1:0]    cfg_wdata_i,
  input  logic [`REFMUX_NUM_CHAN-1:0]       cmp_i,     // one comparator per channel
  input  refmux_pkg::chan_idx_t             mon_sel_i,
  output logic [3*`REFMUX_NUM_CHAN-1:0]     refmux_o,  // channel k at [3k+2:3k]
  output logic [5:0]                        monitor_o,
  output refmux_pkg::period_count_t         period_count_o
);

  import refmux_pkg::*;

  chan_cfg_t    [`REFMUX_NUM_CHAN-1:0] chan_cfg;    // regs to modulators
  chan_status_t [`REFMUX_NUM_CHAN-1:0] chan_status; // modulators to collector

  ////////////////////
  // config

  refmux_param_regs u_param_regs (
    .clk         (clk),
    .reset_i     (reset_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .chan_cfg_o  (chan_cfg)
  );

  ////////////////////
  // channels

  for (genvar k = 0; k < `REFMUX_NUM_CHAN; k++)
  begin : g_chan
    refmux_modulator u_modulator (
      .clk      (clk),
      .reset_i  (reset_i),
      .cfg_i    (chan_cfg[k]),
      .cmp_i    (cmp_i[k]),
      .status_o (chan_status[k])
    );

    assign refmux_o[3*k +: 3] = chan_status[k].refmux; // pack codes
  end

  ////////////////////
  // monitor

  refmux_monitor_collect u_collect (
    .clk            (clk),
    .reset_i        (reset_i),
    .status_i       (chan_status),
    .mon_sel_i      (mon_sel_i),
    .monitor_o      (monitor_o),
    .period_count_o (period_count_o)
  );

endmodule

/* testbench/refmux_test_tb.sv */
// table-driven testbench for refmux_test_top, phase lengths, comparator and period monitor
// one background channel runs throughout and is checked every cycle against the timing rules
`timescale 1ns/1ps
`include "refmux_config.svh"

module refmux_test_tb;

  import refmux_pkg::*;

  localparam int NUM_ROWS  = 6;
  localparam int BG_CHAN   = 3; // free-running neighbour channel
  localparam int BG_RESET  = 5;
  localparam int BG_FIX    = 7;

  typedef struct packed {
    logic [1:0]  ch;
    logic [7:0]  reset_count;
    logic [7:0]  fix_count;
    logic [7:0]  new_fix;     // nonzero, rewritten inside the first pos phase
    logic [3:0]  periods;
    logic [15:0] cmp_pat;     // bit 2p pos phase p, bit 2p+1 neg phase p
  } row_t;

  logic                            clk = 1'b0;
  logic                            reset_i;
  logic                            cfg_we_i;
  cfg_addr_t                       cfg_addr_i;
  logic [`REFMUX_COUNT_WIDTH-1:0]  cfg_wdata_i;
  logic [`REFMUX_NUM_CHAN-1:0]     cmp_i;
  chan_idx_t                       mon_sel_i;
  logic [3*`REFMUX_NUM_CHAN-1:0]   refmux_o;
  logic [5:0]                      monitor_o;
  period_count_t                   period_count_o;

  row_t                        rows [NUM_ROWS];
  logic [`REFMUX_NUM_CHAN-1:0] run_mask = '0; // copy of the run register
  logic                        bg_on    = 1'b0;
  int                          bg_n     = 0;  // edges since the background run write
  int                          cycles   = 0;
  int                          limit    = 1000000;

  refmux_test_top UUT (
    .clk            (clk),
    .reset_i        (reset_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cmp_i          (cmp_i),
    .mon_sel_i      (mon_sel_i),
    .refmux_o       (refmux_o),
    .monitor_o      (monitor_o),
    .period_count_o (period_count_o)
  );

  always #5 clk = ~clk; // 10 ns period

  ////////////////////
  // helpers

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  function automatic logic [2:0] chan_code(input int ch);
    return refmux_o[3*ch +: 3];
  endfunction

  // code after n edges past the run write, constant counts
  function automatic logic [2:0] expected_code(input int n, input int rc, input int fc);
    int m;
    m = n - rc - 3; // cycles into the fix phases
    if (n < 2)
      return REFMUX_NONE;
    if (m < 0)
      return REFMUX_RESET;
    if (((m / (fc + 1)) % 2) == 0)
      return REFMUX_POS;
    return REFMUX_NEG;
  endfunction

  function automatic int rand_count();
    return ($urandom % 20) + 1; // 1 to 20
  endfunction

  // called on a falling edge, returns on the one after the write edge
  task automatic write_reg(input cfg_addr_t addr, input logic [31:0] data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data[`REFMUX_COUNT_WIDTH-1:0];
    @(posedge clk);
    @(negedge clk);
    cfg_we_i = 1'b0;
  endtask

  task automatic set_row(input int idx, input int ch, input int rc, input int fc,
                         input int new_fix, input int periods);
    rows[idx].ch          = ch[1:0];
    rows[idx].reset_count = rc[7:0];
    rows[idx].fix_count   = fc[7:0];
    rows[idx].new_fix     = new_fix[7:0];
    rows[idx].periods     = periods[3:0];
    rows[idx].cmp_pat     = $urandom; // one level per fix phase
  endtask

  task automatic fill_table();
    set_row(0, 0, rand_count(), rand_count(), 0, 3);
    set_row(1, 1, rand_count(), rand_count(), 0, 2);
    set_row(2, 2, 4, 3, 9, 3); // fix count rewritten mid phase
    set_row(3, 1, rand_count(), rand_count(), 0, 2); // restart, count clears
    set_row(4, 0, 1, 1, 0, 3); // shortest phases
    set_row(5, 2, rand_count(), rand_count(), 0, 2);
  endtask

  function automatic int run_limit();
    int total;
    int fix;
    int i;
    total = 0;
    for (i = 0; i < NUM_ROWS; i++)
    begin
      fix = (rows[i].new_fix > rows[i].fix_count) ? rows[i].new_fix : rows[i].fix_count;
      total += (rows[i].reset_count + 2 * fix) * (rows[i].periods + 2);
    end
    return total + 200;
  endfunction

  ////////////////////
  // phase runner

  // starts on the first falling edge of a phase, ends on the first one of the next
  task automatic run_phase(input int ch, input logic [2:0] code, input int len,
                           input logic [5:0] exp_mon, input int exp_cnt, input int new_fix);
    int n;
    n = 0;
    check_value("refmux_o phase code", chan_code(ch), code);
    while ((chan_code(ch) == code) && (n <= len + 1))
    begin
      if (n == 1)
      begin
        // monitor lags the status by one register
        check_value("monitor_o", monitor_o, exp_mon);
        check_value("period_count_o", period_count_o, exp_cnt);
        if (new_fix > 0)
        begin
          cfg_we_i    = 1'b1;
          cfg_addr_i  = cfg_addr_t'(2 * ch + 1);
          cfg_wdata_i = new_fix;
        end
      end
      n++;
      @(negedge clk);
      cfg_we_i = 1'b0;
    end
    check_value("refmux_o phase length", n, len + 1);
  endtask

  task automatic start_background();
    write_reg(cfg_addr_t'(2 * BG_CHAN), BG_RESET);
    write_reg(cfg_addr_t'(2 * BG_CHAN + 1), BG_FIX);
    run_mask[BG_CHAN] = 1'b1;
    write_reg(`REFMUX_RUN_ADDR, run_mask);
    bg_on = 1'b1; // counting starts at the write edge
  endtask

  task automatic run_row(input row_t r);
    int   ch;
    int   fix;
    int   p;
    logic last_pos;
    logic last_neg;
    logic b;
    ch       = r.ch;
    fix      = r.fix_count;
    last_pos = 1'b0;
    last_neg = 1'b0;
    mon_sel_i = chan_idx_t'(ch);
    write_reg(cfg_addr_t'(2 * ch), r.reset_count);
    write_reg(cfg_addr_t'(2 * ch + 1), r.fix_count);
    run_mask[ch] = 1'b1;
    write_reg(`REFMUX_RUN_ADDR, run_mask);
    check_value("refmux_o before start", chan_code(ch), REFMUX_NONE);
    @(negedge clk);
    check_value("refmux_o in start", chan_code(ch), REFMUX_NONE);
    @(negedge clk);
    run_phase(ch, REFMUX_RESET, r.reset_count, 6'b010000, 0, 0);
    for (p = 0; p < r.periods; p++)
    begin
      b = r.cmp_pat[2*p];
      cmp_i[ch] = b; // held to the end of the phase
      run_phase(ch, REFMUX_POS, fix, {1'b0, 1'b1, last_neg, last_pos, 2'b01}, p,
                (p == 0) ? int'(r.new_fix) : 0);
      last_pos = b;
      if ((p == 0) && (r.new_fix != 0))
        fix = r.new_fix; // new length from the next phase on
      b = r.cmp_pat[2*p+1];
      cmp_i[ch] = b;
      run_phase(ch, REFMUX_NEG, fix, {1'b0, 1'b1, last_neg, last_pos, 2'b10}, p, 0);
      last_neg = b;
    end
    // last neg sample and count show one cycle into the next pos phase
    check_value("refmux_o after last period", chan_code(ch), REFMUX_POS);
    @(negedge clk);
    check_value("monitor_o", monitor_o, {1'b0, 1'b1, last_neg, last_pos, 2'b01});
    check_value("period_count_o", period_count_o, r.periods);
    run_mask[ch] = 1'b0;
    write_reg(`REFMUX_RUN_ADDR, run_mask);
    @(negedge clk);
    check_value("refmux_o after stop", chan_code(ch), REFMUX_NONE);
  endtask

  ////////////////////
  // background channel and timeout

  always @(posedge clk)
  begin
    cycles++;
    if (bg_on)
      bg_n <= bg_n + 1;
    if (cycles > limit)
    begin
      $display("timeout after %0d cycles, a channel never left its phase", cycles);
      $display("SIMULATION FAILED");
      $fatal(1, "run limit reached");
    end
  end

  always @(negedge clk)
  begin
    if (bg_n > 0)
      check_value("refmux_o background channel", chan_code(BG_CHAN),
                  expected_code(bg_n, BG_RESET, BG_FIX));
  end

  ////////////////////
  // main sequence

  initial
  begin
    int i;
    reset_i     = 1'b1;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    cmp_i       = '0;
    mon_sel_i   = '0;
    void'($urandom(10181)); // seeds this thread
    fill_table();
    limit = run_limit();
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    check_value("refmux_o after reset", refmux_o, '0);
    check_value("monitor_o after reset", monitor_o, '0);
    check_value("period_count_o after reset", period_count_o, '0);
    start_background();
    for (i = 0; i < NUM_ROWS; i++)
      run_row(rows[i]);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
